// ==== Bender.yml ====
package:
  name: pcie_cfg

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/pcie_cfg_pkg.sv
      - logic/cfg_tlp_decoder.sv
      - logic/cfg_space_regs.sv
      - logic/cfg_cpl_builder.sv
      - logic/tlp_arb_mux.sv
      - logic/pcie_cfg_wrapper.sv
      - logic/pcie_cfg_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_pcie_cfg_top.sv

// ==== files.f ====
+incdir+logic
logic/pcie_cfg_pkg.sv
logic/cfg_tlp_decoder.sv
logic/cfg_space_regs.sv
logic/cfg_cpl_builder.sv
logic/tlp_arb_mux.sv
logic/pcie_cfg_wrapper.sv
logic/pcie_cfg_top.sv
test/tb_pcie_cfg_top.sv

// ==== logic/cfg_cpl_builder.sv ====
`timescale 1ns/1ps

module cfg_cpl_builder
  import pcie_cfg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  cfg_rsp_t  rsp_i,
  input  logic      rsp_valid_i,
  output tlp_beat_t cpl_beat_o,
  output logic      cpl_valid_o,
  input  logic      cpl_ready_i,
  output logic      cpl_busy_o
);

  logic       busy_q;
  logic [1:0] beat_cnt_q;
  cfg_rsp_t   rsp_q;
  logic [1:0] last_idx;
  logic [7:0] fmt_type;

  // CplD carries rdata as a fourth beat
  assign last_idx = rsp_q.has_data ? 2'd3 : 2'd2;
  assign fmt_type = rsp_q.has_data ? CPLD : CPL;

  always_comb begin
    cpl_beat_o.keep = 4'hf;
    cpl_beat_o.last = (beat_cnt_q == last_idx);
    case (beat_cnt_q)
      2'd0: cpl_beat_o.data = {fmt_type, 14'h0000, 9'h000, rsp_q.has_data};
      2'd1: cpl_beat_o.data = {rsp_q.completer_id, rsp_q.status, 1'b0, 12'd4};
      2'd2: cpl_beat_o.data = {rsp_q.requester_id, rsp_q.tag, 8'h00};
      default: cpl_beat_o.data = rsp_q.rdata;
    endcase
  end

  assign cpl_valid_o = busy_q;
  assign cpl_busy_o  = busy_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      beat_cnt_q <= '0;
    end else if (rsp_valid_i) begin
      busy_q     <= 1'b1;
      beat_cnt_q <= '0;
    end else if (cpl_valid_o && cpl_ready_i) begin
      if (cpl_beat_o.last) begin
        busy_q <= 1'b0;
      end else begin
        beat_cnt_q <= beat_cnt_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_valid_i) begin
      rsp_q <= rsp_i;
    end
  end

  a_no_rsp_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |-> !cpl_busy_o);

endmodule

// ==== logic/cfg_space_regs.sv ====
`timescale 1ns/1ps
`include "pcie_cfg_config.svh"

module cfg_space_regs
  import pcie_cfg_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  cfg_req_t req_i,
  input  logic     req_valid_i,
  output cfg_rsp_t rsp_o,
  output logic     rsp_valid_o,
  output logic     mem_en_o,
  output logic     bus_master_en_o
);

  localparam logic [31:0] BAR0_WMASK = ~((32'd1 << `CFG_BAR0_SIZE_LOG2) - 32'd1);

  logic [15:0] cmd_q;
  logic [31:0] bar0_q;
  logic [31:0] rd_data;
  logic [31:0] wr_mask;
  logic [31:0] wr_data;
  logic        wr_en;

  always_comb begin
    rd_data = '0;
    wr_mask = '0;
    case (req_i.dword_addr)
      10'd0: rd_data = {`CFG_DEVICE_ID, `CFG_VENDOR_ID};
      10'd1: begin
        rd_data = {16'h0000, cmd_q};
        wr_mask = {16'h0000, `CFG_CMD_WMASK};
      end
      10'd4: begin
        rd_data = bar0_q;
        wr_mask = BAR0_WMASK;
      end
      default: ;
    endcase
    // Byte enables narrow the per-dword mask
    wr_mask = wr_mask & {{8{req_i.first_be[3]}}, {8{req_i.first_be[2]}},
                         {8{req_i.first_be[1]}}, {8{req_i.first_be[0]}}};
    wr_data = (rd_data & ~wr_mask) | (req_i.wdata & wr_mask);
  end

  assign wr_en = req_valid_i && req_i.is_write && !req_i.is_type1;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmd_q       <= '0;
      bar0_q      <= '0;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= req_valid_i;
      if (wr_en && req_i.dword_addr == 10'd1) begin
        cmd_q <= wr_data[15:0];
      end
      if (wr_en && req_i.dword_addr == 10'd4) begin
        bar0_q <= wr_data;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      rsp_o.has_data     <= !req_i.is_write && !req_i.is_type1;
      rsp_o.status       <= req_i.is_type1 ? UR : SC;
      rsp_o.requester_id <= req_i.requester_id;
      rsp_o.tag          <= req_i.tag;
      rsp_o.completer_id <= req_i.completer_id;
      rsp_o.rdata        <= req_i.is_type1 ? 32'h0 : rd_data;
    end
  end

  assign mem_en_o        = cmd_q[1];
  assign bus_master_en_o = cmd_q[2];

  a_addr_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_valid_i && !req_i.is_type1) |-> (req_i.dword_addr < `CFG_NUM_DWORDS));

endmodule

// ==== logic/cfg_tlp_decoder.sv ====
`timescale 1ns/1ps

module cfg_tlp_decoder
  import pcie_cfg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  tlp_beat_t rx_beat_i,
  input  logic      rx_valid_i,
  output logic      rx_ready_o,
  output tlp_beat_t fwd_beat_o,
  output logic      fwd_valid_o,
  input  logic      fwd_ready_i,
  output cfg_req_t  req_o,
  output logic      req_valid_o,
  input  logic      cpl_busy_i
);

  typedef enum logic [1:0] {S_IDLE, S_CFG, S_FWD} state_e;

  state_e     state_q;
  logic [1:0] beat_cnt_q;
  logic       req_valid_q;
  logic       rsp_wait_q;
  logic       first_is_cfg;
  logic       cfg_blocked;
  logic       rx_fire;
  cfg_req_t   req_q;

  function automatic logic is_cfg_type(input logic [7:0] ft);
    return (ft == CFG_RD0) || (ft == CFG_WR0) || (ft == CFG_RD1) || (ft == CFG_WR1);
  endfunction

  assign first_is_cfg = is_cfg_type(rx_beat_i.data[31:24]);
  // Covers the gap between req strobe and builder busy
  assign cfg_blocked  = cpl_busy_i || req_valid_q || rsp_wait_q;
  assign rx_fire      = rx_valid_i && rx_ready_o;

  assign fwd_beat_o  = rx_beat_i;
  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;

  always_comb begin
    rx_ready_o  = 1'b0;
    fwd_valid_o = 1'b0;
    case (state_q)
      S_IDLE: begin
        if (first_is_cfg) begin
          rx_ready_o = !cfg_blocked;
        end else begin
          fwd_valid_o = rx_valid_i;
          rx_ready_o  = fwd_ready_i;
        end
      end
      S_CFG: rx_ready_o = 1'b1;
      S_FWD: begin
        fwd_valid_o = rx_valid_i;
        rx_ready_o  = fwd_ready_i;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= S_IDLE;
      beat_cnt_q  <= '0;
      req_valid_q <= 1'b0;
      rsp_wait_q  <= 1'b0;
    end else begin
      req_valid_q <= 1'b0;
      rsp_wait_q  <= req_valid_q;
      if (rx_fire) begin
        case (state_q)
          S_IDLE: begin
            beat_cnt_q <= 2'd1;
            if (first_is_cfg) begin
              state_q     <= rx_beat_i.last ? S_IDLE : S_CFG;
              req_valid_q <= rx_beat_i.last;
            end else if (!rx_beat_i.last) begin
              state_q <= S_FWD;
            end
          end
          S_CFG: begin
            if (beat_cnt_q != 2'd3) begin
              beat_cnt_q <= beat_cnt_q + 2'd1;
            end
            if (rx_beat_i.last) begin
              state_q     <= S_IDLE;
              req_valid_q <= 1'b1;
            end
          end
          default: begin
            if (rx_beat_i.last) begin
              state_q <= S_IDLE;
            end
          end
        endcase
      end
    end
  end

  // Header fields, picked from the beat they live in
  always_ff @(posedge clk_i) begin
    if (rx_fire && state_q == S_IDLE && first_is_cfg) begin
      req_q.is_write <= rx_beat_i.data[30];
      req_q.is_type1 <= rx_beat_i.data[24];
      req_q.wdata    <= '0;
    end
    if (rx_fire && state_q == S_CFG) begin
      case (beat_cnt_q)
        2'd1: begin
          req_q.requester_id <= rx_beat_i.data[31:16];
          req_q.tag          <= rx_beat_i.data[15:8];
          req_q.first_be     <= rx_beat_i.data[3:0];
        end
        2'd2: begin
          req_q.completer_id <= rx_beat_i.data[31:16];
          req_q.dword_addr   <= rx_beat_i.data[11:2];
        end
        2'd3: req_q.wdata <= rx_beat_i.data;
        default: ;
      endcase
    end
  end

  a_no_req_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_valid_o |-> !cpl_busy_i);

  // Rest of a configuration TLP stays off fwd until its request fires
  a_no_cfg_on_fwd: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (rx_fire && state_q == S_IDLE && first_is_cfg) |=> (!fwd_valid_o until req_valid_q));

endmodule

// ==== logic/pcie_cfg_config.svh ====
`ifndef PCIE_CFG_CONFIG_SVH
`define PCIE_CFG_CONFIG_SVH

// Identity returned in dword 0
`define CFG_VENDOR_ID 16'habcd
`define CFG_DEVICE_ID 16'h0042

// BAR0 decodes a 4 KiB window
`define CFG_BAR0_SIZE_LOG2 12

// Memory enable and bus master enable
`define CFG_CMD_WMASK 16'h0006

`define CFG_NUM_DWORDS 16

`endif

// ==== logic/pcie_cfg_pkg.sv ====
package pcie_cfg_pkg;

  // One 32-bit stream beat
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  keep;
    logic        last;
  } tlp_beat_t;

  // Combined fmt/type in DW0 bits 31:24
  typedef enum logic [7:0] {
    CFG_RD0 = 8'h04,
    CFG_WR0 = 8'h44,
    CFG_RD1 = 8'h05,
    CFG_WR1 = 8'h45,
    CPL     = 8'h0a,
    CPLD    = 8'h4a
  } tlp_fmt_type_e;

  typedef enum logic [2:0] {
    SC = 3'b000,
    UR = 3'b001
  } cpl_status_e;

  typedef struct packed {
    logic        is_write;
    logic        is_type1;
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [15:0] completer_id;
    logic [9:0]  dword_addr;
    logic [3:0]  first_be;
    logic [31:0] wdata;
  } cfg_req_t;

  typedef struct packed {
    logic        has_data;
    cpl_status_e status;
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [15:0] completer_id;
    logic [31:0] rdata;
  } cfg_rsp_t;

endpackage

// ==== logic/pcie_cfg_top.sv ====
`timescale 1ns/1ps

module pcie_cfg_top
  import pcie_cfg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  tlp_beat_t rx_beat_i,
  input  logic      rx_valid_i,
  output logic      rx_ready_o,
  output tlp_beat_t usr_rx_beat_o,
  output logic      usr_rx_valid_o,
  input  logic      usr_rx_ready_i,
  input  tlp_beat_t usr_tx_beat_i,
  input  logic      usr_tx_valid_i,
  output logic      usr_tx_ready_o,
  output tlp_beat_t tx_beat_o,
  output logic      tx_valid_o,
  input  logic      tx_ready_i,
  output logic      mem_en_o,
  output logic      bus_master_en_o
);

  tlp_beat_t cpl_beat;
  logic      cpl_valid;
  logic      cpl_ready;
  tlp_beat_t arb_beat [2];
  logic      arb_valid [2];
  logic      arb_ready [2];

  pcie_cfg_wrapper pcie_cfg_wrapper_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .rx_beat_i      (rx_beat_i),
    .rx_valid_i     (rx_valid_i),
    .rx_ready_o     (rx_ready_o),
    .fwd_beat_o     (usr_rx_beat_o),
    .fwd_valid_o    (usr_rx_valid_o),
    .fwd_ready_i    (usr_rx_ready_i),
    .cpl_beat_o     (cpl_beat),
    .cpl_valid_o    (cpl_valid),
    .cpl_ready_i    (cpl_ready),
    .mem_en_o       (mem_en_o),
    .bus_master_en_o(bus_master_en_o)
  );

  // User tx on port 0 takes priority
  assign arb_beat[0]    = usr_tx_beat_i;
  assign arb_valid[0]   = usr_tx_valid_i;
  assign usr_tx_ready_o = arb_ready[0];
  assign arb_beat[1]    = cpl_beat;
  assign arb_valid[1]   = cpl_valid;
  assign cpl_ready      = arb_ready[1];

  tlp_arb_mux #(
    .BEAT_T(tlp_beat_t)
  ) tx_arb_mux_inst (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .s_beat_i (arb_beat),
    .s_valid_i(arb_valid),
    .s_ready_o(arb_ready),
    .m_beat_o (tx_beat_o),
    .m_valid_o(tx_valid_o),
    .m_ready_i(tx_ready_i)
  );

endmodule

// ==== logic/pcie_cfg_wrapper.sv ====
`timescale 1ns/1ps

module pcie_cfg_wrapper
  import pcie_cfg_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  tlp_beat_t rx_beat_i,
  input  logic      rx_valid_i,
  output logic      rx_ready_o,
  output tlp_beat_t fwd_beat_o,
  output logic      fwd_valid_o,
  input  logic      fwd_ready_i,
  output tlp_beat_t cpl_beat_o,
  output logic      cpl_valid_o,
  input  logic      cpl_ready_i,
  output logic      mem_en_o,
  output logic      bus_master_en_o
);

  cfg_req_t req;
  logic     req_valid;
  cfg_rsp_t rsp;
  logic     rsp_valid;
  logic     cpl_busy;

  cfg_tlp_decoder cfg_tlp_decoder_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rx_beat_i  (rx_beat_i),
    .rx_valid_i (rx_valid_i),
    .rx_ready_o (rx_ready_o),
    .fwd_beat_o (fwd_beat_o),
    .fwd_valid_o(fwd_valid_o),
    .fwd_ready_i(fwd_ready_i),
    .req_o      (req),
    .req_valid_o(req_valid),
    .cpl_busy_i (cpl_busy)
  );

  cfg_space_regs cfg_space_regs_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .req_i          (req),
    .req_valid_i    (req_valid),
    .rsp_o          (rsp),
    .rsp_valid_o    (rsp_valid),
    .mem_en_o       (mem_en_o),
    .bus_master_en_o(bus_master_en_o)
  );

  cfg_cpl_builder cfg_cpl_builder_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rsp_i      (rsp),
    .rsp_valid_i(rsp_valid),
    .cpl_beat_o (cpl_beat_o),
    .cpl_valid_o(cpl_valid_o),
    .cpl_ready_i(cpl_ready_i),
    .cpl_busy_o (cpl_busy)
  );

endmodule

// ==== logic/tlp_arb_mux.sv ====
`timescale 1ns/1ps

module tlp_arb_mux
  import pcie_cfg_pkg::*;
#(
  parameter type BEAT_T = tlp_beat_t
) (
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  BEAT_T s_beat_i [2],
  input  logic  s_valid_i [2],
  output logic  s_ready_o [2],
  output BEAT_T m_beat_o,
  output logic  m_valid_o,
  input  logic  m_ready_i
);

  logic lock_q;
  logic sel_q;
  logic sel;
  logic m_fire;

  // Low index wins unless a packet is already under way
  always_comb begin
    if (lock_q) begin
      sel = sel_q;
    end else if (s_valid_i[0]) begin
      sel = 1'b0;
    end else begin
      sel = 1'b1;
    end
  end

  assign m_beat_o     = s_beat_i[sel];
  assign m_valid_o    = s_valid_i[sel];
  assign s_ready_o[0] = m_ready_i && !sel;
  assign s_ready_o[1] = m_ready_i && sel;
  assign m_fire       = m_valid_o && m_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q <= 1'b0;
      sel_q  <= 1'b0;
    end else if (m_fire) begin
      sel_q  <= sel;
      lock_q <= !m_beat_o.last;
    end
  end

  a_grant_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (m_fire && !m_beat_o.last) |=> (sel == $past(sel)));

endmodule

// ==== test/tb_pcie_cfg_top.sv ====
`timescale 1ns/1ps
`include "pcie_cfg_config.svh"

module tb_pcie_cfg_top
  import pcie_cfg_pkg::*;
();

  localparam int CLK_PERIOD     = 100;
  localparam int DRIVE_DELAY    = 10;
  localparam int NUM_RX_OPS     = 200;
  localparam int NUM_UTX_PKTS   = 60;
  // About 300 transactions of under 20 cycles each, plus stalls
  localparam int TIMEOUT_CYCLES = 20000;

  logic      clk;
  logic      rst_n;
  tlp_beat_t rx_beat;
  logic      rx_valid;
  logic      rx_ready;
  tlp_beat_t usr_rx_beat;
  logic      usr_rx_valid;
  logic      usr_rx_ready;
  tlp_beat_t usr_tx_beat;
  logic      usr_tx_valid;
  logic      usr_tx_ready;
  tlp_beat_t tx_beat;
  logic      tx_valid;
  logic      tx_ready;
  logic      mem_en;
  logic      bus_master_en;

  logic [31:0] cfg_model [16];
  tlp_beat_t   exp_cpl [$];
  tlp_beat_t   exp_utx [$];
  tlp_beat_t   exp_urx [$];
  logic [1:0]  exp_cmd [$];
  tlp_beat_t   exp_tx_beat;
  tlp_beat_t   exp_rx_beat;
  logic [1:0]  exp_en;
  logic        tx_in_pkt;
  logic        tx_is_cpl;
  logic [31:0] lcg_state;
  logic [31:0] stim_rnd;
  logic [31:0] ready_rnd;
  logic [3:0]  stim_addr;
  logic [7:0]  tag_cnt;
  int          errors;
  int          checks;
  int          cycles;

  pcie_cfg_top i_pcie_cfg_top (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .rx_beat_i      (rx_beat),
    .rx_valid_i     (rx_valid),
    .rx_ready_o     (rx_ready),
    .usr_rx_beat_o  (usr_rx_beat),
    .usr_rx_valid_o (usr_rx_valid),
    .usr_rx_ready_i (usr_rx_ready),
    .usr_tx_beat_i  (usr_tx_beat),
    .usr_tx_valid_i (usr_tx_valid),
    .usr_tx_ready_o (usr_tx_ready),
    .tx_beat_o      (tx_beat),
    .tx_valid_o     (tx_valid),
    .tx_ready_i     (tx_ready),
    .mem_en_o       (mem_en),
    .bus_master_en_o(bus_master_en)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic tlp_beat_t mk_beat(input logic [31:0] data, input logic last);
    tlp_beat_t b;
    b.data = data;
    b.keep = 4'hf;
    b.last = last;
    return b;
  endfunction

  // Writable bits per dword of configuration space
  function automatic logic [31:0] dword_wmask(input logic [3:0] addr);
    case (addr)
      4'd1:    return {16'h0000, `CFG_CMD_WMASK};
      4'd4:    return {{(32 - `CFG_BAR0_SIZE_LOG2){1'b1}}, {`CFG_BAR0_SIZE_LOG2{1'b0}}};
      default: return 32'h0;
    endcase
  endfunction

  // Reference access: returns the value before the write, then updates the model
  function automatic logic [31:0] cfg_ref(input logic wr, input logic [3:0] addr,
                                          input logic [3:0] be, input logic [31:0] wdata);
    logic [31:0] old;
    logic [31:0] mask;
    old  = cfg_model[addr];
    mask = dword_wmask(addr) & {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    if (wr) begin
      cfg_model[addr] = (old & ~mask) | (wdata & mask);
    end
    return old;
  endfunction

  task automatic log_mismatch(input string msg);
    $display("ERR %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic drive_rx(input tlp_beat_t b);
    rx_beat  = b;
    rx_valid = 1'b1;
    @(negedge clk);
    while (!rx_ready) @(negedge clk);
    @(posedge clk);
    #DRIVE_DELAY;
    rx_valid = 1'b0;
  endtask

  task automatic drive_utx(input tlp_beat_t b);
    usr_tx_beat  = b;
    usr_tx_valid = 1'b1;
    @(negedge clk);
    while (!usr_tx_ready) @(negedge clk);
    @(posedge clk);
    #DRIVE_DELAY;
    usr_tx_valid = 1'b0;
  endtask

  task automatic cfg_access(input logic wr, input logic t1, input logic [3:0] addr,
                            input logic [3:0] be, input logic [31:0] wdata);
    logic [31:0]   r;
    logic [7:0]    tag;
    logic [31:0]   rdata;
    logic          has_data;
    cpl_status_e   status;
    tlp_fmt_type_e ft;
    r        = lcg_next();
    tag      = tag_cnt;
    tag_cnt  = tag_cnt + 8'd1;
    rdata    = t1 ? 32'h0 : cfg_ref(wr, addr, be, wdata);
    has_data = !wr && !t1;
    status   = t1 ? UR : SC;
    ft       = t1 ? (wr ? CFG_WR1 : CFG_RD1) : (wr ? CFG_WR0 : CFG_RD0);
    exp_cpl.push_back(mk_beat({has_data ? CPLD : CPL, 14'h0000, 9'h000, has_data}, 1'b0));
    exp_cpl.push_back(mk_beat({r[15:0], status, 1'b0, 12'd4}, 1'b0));
    exp_cpl.push_back(mk_beat({r[31:16], tag, 8'h00}, !has_data));
    if (has_data) begin
      exp_cpl.push_back(mk_beat(rdata, 1'b1));
    end
    exp_cmd.push_back({cfg_model[1][2], cfg_model[1][1]});
    drive_rx(mk_beat({ft, 14'h0000, 10'd1}, 1'b0));
    drive_rx(mk_beat({r[31:16], tag, 4'h0, be}, 1'b0));
    drive_rx(mk_beat({r[15:0], 4'h0, 6'h00, addr, 2'b00}, !wr));
    if (wr) begin
      drive_rx(mk_beat(wdata, 1'b1));
    end
  endtask

  // Memory request that the decoder must pass to usr_rx
  task automatic send_mem_rx();
    logic [31:0] r;
    int          nbeats;
    tlp_beat_t   b;
    r      = lcg_next();
    nbeats = 2 + int'(r[1:0]);
    for (int i = 0; i < nbeats; i++) begin
      if (i == 0) begin
        b = mk_beat({r[2] ? 8'h40 : 8'h00, 14'h0000, 10'(nbeats - 1)}, 1'b0);
      end else begin
        b = mk_beat(lcg_next(), i == nbeats - 1);
      end
      exp_urx.push_back(b);
      drive_rx(b);
    end
  endtask

  task automatic send_usr_tx(input logic [7:0] tag);
    logic [31:0] r;
    int          nbeats;
    tlp_beat_t   b;
    r      = lcg_next();
    nbeats = 2 + int'(r[1:0]);
    for (int i = 0; i < nbeats; i++) begin
      if (i == 0) begin
        b = mk_beat({8'h40, 14'h0000, 10'(nbeats - 1)}, 1'b0);
      end else if (i == 1) begin
        b = mk_beat({16'h0100, tag, 8'h0f}, nbeats == 2);
      end else begin
        b = mk_beat(lcg_next(), i == nbeats - 1);
      end
      exp_utx.push_back(b);
      drive_utx(b);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Random back-pressure on both output streams
  initial begin
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      ready_rnd    = lcg_next();
      tx_ready     = ready_rnd[1:0] != 2'b00;
      usr_rx_ready = ready_rnd[3:2] != 2'b00;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  // Tx side, routed by the first header beat of each packet
  always @(negedge clk) begin
    if (rst_n && tx_valid && tx_ready) begin
      if (!tx_in_pkt) begin
        tx_is_cpl = (tx_beat.data[31:24] == CPL) || (tx_beat.data[31:24] == CPLD);
      end
      if (tx_is_cpl) begin
        if (exp_cpl.size() == 0) begin
          $display("Completion beat %h appeared on tx with none expected", tx_beat.data);
          errors++;
        end else begin
          exp_tx_beat = exp_cpl.pop_front();
          checks++;
          if (tx_beat !== exp_tx_beat) begin
            log_mismatch($sformatf("completion beat %h, expected %h", tx_beat, exp_tx_beat));
          end
        end
        if (tx_beat.last && exp_cmd.size() != 0) begin
          exp_en = exp_cmd.pop_front();
          checks++;
          if ({bus_master_en, mem_en} !== exp_en) begin
            log_mismatch($sformatf("command outputs %b, expected %b",
                                   {bus_master_en, mem_en}, exp_en));
          end
        end
      end else begin
        if (exp_utx.size() == 0) begin
          $display("User beat %h appeared on tx with none expected", tx_beat.data);
          errors++;
        end else begin
          exp_tx_beat = exp_utx.pop_front();
          checks++;
          if (tx_beat !== exp_tx_beat) begin
            log_mismatch($sformatf("user tx beat %h, expected %h", tx_beat, exp_tx_beat));
          end
        end
      end
      tx_in_pkt = !tx_beat.last;
    end
  end

  always @(negedge clk) begin
    if (rst_n && usr_rx_valid && usr_rx_ready) begin
      if (exp_urx.size() == 0) begin
        $display("Beat %h appeared on usr_rx with none expected", usr_rx_beat.data);
        errors++;
      end else begin
        exp_rx_beat = exp_urx.pop_front();
        checks++;
        if (usr_rx_beat !== exp_rx_beat) begin
          log_mismatch($sformatf("usr_rx beat %h, expected %h", usr_rx_beat, exp_rx_beat));
        end
      end
    end
  end

  initial begin
    rst_n        = 1'b0;
    rx_beat      = '0;
    rx_valid     = 1'b0;
    usr_rx_ready = 1'b1;
    usr_tx_beat  = '0;
    usr_tx_valid = 1'b0;
    tx_ready     = 1'b1;
    tx_in_pkt    = 1'b0;
    tx_is_cpl    = 1'b0;
    lcg_state    = 32'h31f2b433;
    tag_cnt      = 8'h00;
    errors       = 0;
    checks       = 0;
    for (int i = 0; i < 16; i++) begin
      cfg_model[i] = 32'h0;
    end
    cfg_model[0] = {`CFG_DEVICE_ID, `CFG_VENDOR_ID};

    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    checks++;
    if (mem_en !== 1'b0 || bus_master_en !== 1'b0 || tx_valid !== 1'b0) begin
      log_mismatch("outputs not idle after reset");
    end

    // IDs and reset values
    cfg_access(1'b0, 1'b0, 4'd0, 4'hf, 32'h0);
    cfg_access(1'b0, 1'b0, 4'd1, 4'hf, 32'h0);
    cfg_access(1'b0, 1'b0, 4'd4, 4'hf, 32'h0);

    fork
      begin
        repeat (NUM_RX_OPS) begin
          stim_rnd  = lcg_next();
          stim_addr = stim_rnd[4] ? (stim_rnd[5] ? 4'd1 : 4'd4) : stim_rnd[11:8];
          case (stim_rnd[2:0])
            3'd0, 3'd1: cfg_access(1'b1, 1'b0, stim_addr, stim_rnd[15:12], lcg_next());
            3'd2, 3'd3: cfg_access(1'b0, 1'b0, stim_addr, 4'hf, 32'h0);
            3'd4:       cfg_access(stim_rnd[3], 1'b1, stim_addr, stim_rnd[15:12], lcg_next());
            default:    send_mem_rx();
          endcase
        end
      end
      begin
        for (int n = 0; n < NUM_UTX_PKTS; n++) begin
          send_usr_tx(8'(n));
          repeat (lcg_next() % 4) begin
            @(posedge clk);
            #DRIVE_DELAY;
          end
        end
      end
    join

    while (exp_cpl.size() != 0 || exp_utx.size() != 0 || exp_urx.size() != 0) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
